//--- rtl/sram_link_bit_counter.sv
/*
 * Down-counter that opens the shift window for one serial word
 * and answers the sequencer request with ack
 */
`timescale 1ns/100ps

module sram_link_bit_counter (
    input  logic csi_clk,
    input  logic rsi_reset_n,
    input  logic req,
    output logic ack,
    output logic active
);
    import sram_link_pkg::*;

    logic [cnt_width-1:0] cnt;
    logic                 req_q;

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            cnt   <= '0;
            req_q <= 1'b0;
            ack   <= 1'b0;
        end
        else
        begin
            req_q <= req;
            if (req && !req_q)
                cnt <= cnt_width'(word_bits);   // Arm on request edge
            else if (cnt != '0)
                cnt <= cnt - 1'b1;

            if (!req)
                ack <= 1'b0;                    // Return to zero phase
            else if (cnt == cnt_width'(1))
                ack <= 1'b1;                    // Last bit shifted
        end
    end

    assign active = (cnt != '0);

    // Sequencer drops req, counter must follow within a cycle
    ack_follows_req: assert property (
        @(posedge csi_clk) disable iff (!rsi_reset_n)
        (!req && ack) |=> !ack
    );

endmodule

//--- rtl/sram_link_pkg.sv
/*
 * Shared widths, control and status bit indices, mode codes
 * and the sequencer state type for the SRAM serial link
 */
package sram_link_pkg;

    // ------------------------------------------------------------
    // Bus and word widths
    // ------------------------------------------------------------
    localparam int avs_width      = 32;
    localparam int mem_addr_width = 10;
    localparam int mem_data_width = 8;
    localparam int word_bits      = mem_addr_width + mem_data_width; // 18 serial bits
    localparam int cnt_width      = 5;

    // ------------------------------------------------------------
    // Control word bit positions
    // ------------------------------------------------------------
    localparam int idx_ctrl_bgn  = 0;
    localparam int idx_ctrl_load = 1;   // One-shot, starts a transfer
    localparam int idx_mod0      = 2;
    localparam int idx_mod1      = 3;
    localparam int idx_app_done  = 4;
    localparam int idx_cpu_bgn   = 5;   // One-shot
    localparam int idx_rst_n     = 6;
    localparam int idx_cpu_wait  = 7;

    // Status word bit positions
    localparam int idx_ctrl_rdy  = 0;
    localparam int idx_nxt_end   = 1;
    localparam int idx_nxt_cont  = 2;
    localparam int idx_app_start = 3;
    localparam int idx_busy      = 4;

    // Mode codes as {mod1, mod0} in the control word
    localparam logic [1:0] mode_send    = 2'b00; // Host to chip
    localparam logic [1:0] mode_receive = 2'b10; // Chip to host

    // Transfer sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_prime,
        st_run,
        st_release
    } seq_state_t;

endpackage

//--- rtl/sram_link_regs.sv
/*
 * Avalon register block with control word, address and data registers,
 * one-shot pulse generation and the status word
 */
`timescale 1ns/100ps

module sram_link_regs (
    input  logic                                   csi_clk,
    input  logic                                   rsi_reset_n,
    input  logic [sram_link_pkg::avs_width-1:0]    cpuctrl_writedata,
    input  logic                                   cpuctrl_write,
    input  logic [sram_link_pkg::avs_width-1:0]    sram_addr_wrt_writedata,
    input  logic                                   sram_addr_wrt_write,
    input  logic [sram_link_pkg::avs_width-1:0]    sram_data_wrt_writedata,
    input  logic                                   sram_data_wrt_write,
    input  logic                                   ctrl_rdy,
    input  logic                                   nxt_end,
    input  logic                                   nxt_cont,
    input  logic                                   app_start,
    input  logic                                   busy,
    output logic [sram_link_pkg::avs_width-1:0]    cpustat_readdata,
    output logic [sram_link_pkg::mem_addr_width-1:0] addr,
    output logic [sram_link_pkg::mem_data_width-1:0] data,
    output logic [1:0]                             mode,
    output logic                                   ctrl_bgn,
    output logic                                   rst_n,
    output logic                                   cpu_wait,
    output logic                                   app_done,
    output logic                                   cpu_bgn,
    output logic                                   load_pulse
);
    import sram_link_pkg::*;

    logic write_q;  // Write seen on the previous edge

    // ------------------------------------------------------------
    // Control word levels and one-shot pulses
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            write_q    <= 1'b0;
            cpu_bgn    <= 1'b0;
            load_pulse <= 1'b0;
            ctrl_bgn   <= 1'b0;
            rst_n      <= 1'b0;
            cpu_wait   <= 1'b0;
            app_done   <= 1'b0;
            mode       <= 2'b00;
        end
        else
        begin
            write_q <= cpuctrl_write;
            // Pulse only on the first cycle of a write burst
            cpu_bgn    <= cpuctrl_write & ~write_q & cpuctrl_writedata[idx_cpu_bgn];
            load_pulse <= cpuctrl_write & ~write_q & cpuctrl_writedata[idx_ctrl_load];
            if (cpuctrl_write)
            begin
                ctrl_bgn <= cpuctrl_writedata[idx_ctrl_bgn];
                rst_n    <= cpuctrl_writedata[idx_rst_n];
                cpu_wait <= cpuctrl_writedata[idx_cpu_wait];
                app_done <= cpuctrl_writedata[idx_app_done];
                mode     <= {cpuctrl_writedata[idx_mod1], cpuctrl_writedata[idx_mod0]};
            end
        end
    end

    // Word to be sent on the next mode-00 load
    always_ff @(posedge csi_clk)
    begin
        if (sram_addr_wrt_write)
            addr <= sram_addr_wrt_writedata[mem_addr_width-1:0];
        if (sram_data_wrt_write)
            data <= sram_data_wrt_writedata[mem_data_width-1:0];
    end

    // ------------------------------------------------------------
    // Status word
    // ------------------------------------------------------------
    always_comb
    begin
        cpustat_readdata                = '0;
        cpustat_readdata[idx_ctrl_rdy]  = ctrl_rdy;
        cpustat_readdata[idx_nxt_end]   = nxt_end;
        cpustat_readdata[idx_nxt_cont]  = nxt_cont;
        cpustat_readdata[idx_app_start] = app_start;
        cpustat_readdata[idx_busy]      = busy;  // Transfer in progress
    end

    // A held write must not stretch the start pulse
    cpu_bgn_single: assert property (
        @(posedge csi_clk) disable iff (!rsi_reset_n)
        cpu_bgn |=> !cpu_bgn
    );

endmodule

//--- rtl/sram_link_sequencer.sv
/*
 * Transfer FSM that starts one serial transfer per load pulse
 * and runs the four-phase req/ack handshake with the bit counter
 */
`timescale 1ns/100ps

module sram_link_sequencer (
    input  logic       csi_clk,
    input  logic       rsi_reset_n,
    input  logic       load_pulse,
    input  logic [1:0] mode,
    input  logic       ack,
    output logic       req,
    output logic       parallel_load,
    output logic       busy
);
    import sram_link_pkg::*;

    seq_state_t state;
    seq_state_t state_next;
    logic       start_ok;

    // Only the two serial modes start a transfer
    assign start_ok = load_pulse && (mode == mode_send || mode == mode_receive);

    // ------------------------------------------------------------
    // State register and next state
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            state <= st_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (start_ok)
                    state_next = st_prime;
            end
            st_prime:
                state_next = st_run;        // Word loaded, counter armed
            st_run:
            begin
                if (ack)
                    state_next = st_release; // Count done, drop req
            end
            st_release:
            begin
                if (!ack)
                    state_next = st_idle;
            end
            default:
                state_next = st_idle;
        endcase
    end

    // ------------------------------------------------------------
    // Outputs decoded from the state register
    // ------------------------------------------------------------
    assign req           = (state == st_prime) || (state == st_run);
    assign parallel_load = (state == st_prime) && (mode == mode_send);
    assign busy          = (state != st_idle);  // Loads ignored while set

    // New request only once the previous ack has gone low
    req_after_ack_low: assert property (
        @(posedge csi_clk) disable iff (!rsi_reset_n)
        $rose(req) |-> !ack
    );

endmodule

//--- rtl/sram_link_shifter.sv
/*
 * Serial word register with parallel load, right shift
 * filling from the chip, and address/data readback fields
 */
`timescale 1ns/100ps

module sram_link_shifter (
    input  logic                                     csi_clk,
    input  logic                                     rsi_reset_n,
    input  logic                                     parallel_load,
    input  logic                                     active,
    input  logic [sram_link_pkg::mem_addr_width-1:0] addr,
    input  logic [sram_link_pkg::mem_data_width-1:0] data,
    input  logic                                     ctrl_so,
    output logic                                     ctrl_si,
    output logic [sram_link_pkg::mem_addr_width-1:0] rd_addr,
    output logic [sram_link_pkg::mem_data_width-1:0] rd_data
);
    import sram_link_pkg::*;

    logic [word_bits-1:0] word;  // {addr, data}

    // ------------------------------------------------------------
    // Shift register
    // ------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            word <= '0;
        else if (parallel_load)
            word <= {addr, data};
        else if (active)
            word <= {ctrl_so, word[word_bits-1:1]};  // LSB out, chip bit in at top
    end

    // Send side always shows the current LSB
    assign ctrl_si = word[0];

    // Readback fields
    assign rd_addr = word[word_bits-1:mem_data_width];
    assign rd_data = word[mem_data_width-1:0];

endmodule

//--- rtl/sram_link_top.sv
/*
 * Top level joining the register block, sequencer, bit counter
 * and shifter to the Avalon slave ports and the chip pins
 */
`timescale 1ns/100ps

module sram_link_top (
    input  logic                                csi_clk,
    input  logic                                rsi_reset_n,
    // Avalon slave
    input  logic [sram_link_pkg::avs_width-1:0] cpuctrl_writedata,
    input  logic                                cpuctrl_write,
    input  logic [sram_link_pkg::avs_width-1:0] sram_addr_wrt_writedata,
    input  logic                                sram_addr_wrt_write,
    input  logic [sram_link_pkg::avs_width-1:0] sram_data_wrt_writedata,
    input  logic                                sram_data_wrt_write,
    output logic [sram_link_pkg::avs_width-1:0] cpustat_readdata,
    output logic [sram_link_pkg::avs_width-1:0] sram_addr_rd_readdata,
    output logic [sram_link_pkg::avs_width-1:0] sram_data_rd_readdata,
    // Chip pins
    output logic                                cpu_bgn,
    output logic                                ctrl_load,
    output logic                                ctrl_bgn,
    output logic                                mod0,
    output logic                                mod1,
    output logic                                rst_n,
    output logic                                cpu_wait,
    output logic                                app_done,
    output logic                                ctrl_si,
    input  logic                                ctrl_so,
    input  logic                                ctrl_rdy,
    input  logic                                nxt_end,
    input  logic                                nxt_cont,
    input  logic                                app_start
);
    import sram_link_pkg::*;

    logic [mem_addr_width-1:0] addr;
    logic [mem_data_width-1:0] data;
    logic [mem_addr_width-1:0] rd_addr;
    logic [mem_data_width-1:0] rd_data;
    logic [1:0]                mode;
    logic                      load_pulse;
    logic                      busy;
    logic                      req;
    logic                      ack;
    logic                      parallel_load;
    logic                      active;

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------
    sram_link_regs sram_link_regs_i (
        .csi_clk                 (csi_clk),
        .rsi_reset_n             (rsi_reset_n),
        .cpuctrl_writedata       (cpuctrl_writedata),
        .cpuctrl_write           (cpuctrl_write),
        .sram_addr_wrt_writedata (sram_addr_wrt_writedata),
        .sram_addr_wrt_write     (sram_addr_wrt_write),
        .sram_data_wrt_writedata (sram_data_wrt_writedata),
        .sram_data_wrt_write     (sram_data_wrt_write),
        .ctrl_rdy                (ctrl_rdy),
        .nxt_end                 (nxt_end),
        .nxt_cont                (nxt_cont),
        .app_start               (app_start),
        .busy                    (busy),
        .cpustat_readdata        (cpustat_readdata),
        .addr                    (addr),
        .data                    (data),
        .mode                    (mode),
        .ctrl_bgn                (ctrl_bgn),
        .rst_n                   (rst_n),
        .cpu_wait                (cpu_wait),
        .app_done                (app_done),
        .cpu_bgn                 (cpu_bgn),
        .load_pulse              (load_pulse)
    );

    sram_link_sequencer sram_link_sequencer_i (
        .csi_clk       (csi_clk),
        .rsi_reset_n   (rsi_reset_n),
        .load_pulse    (load_pulse),
        .mode          (mode),
        .ack           (ack),
        .req           (req),
        .parallel_load (parallel_load),
        .busy          (busy)
    );

    sram_link_bit_counter sram_link_bit_counter_i (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .req         (req),
        .ack         (ack),
        .active      (active)
    );

    sram_link_shifter sram_link_shifter_i (
        .csi_clk       (csi_clk),
        .rsi_reset_n   (rsi_reset_n),
        .parallel_load (parallel_load),
        .active        (active),
        .addr          (addr),
        .data          (data),
        .ctrl_so       (ctrl_so),
        .ctrl_si       (ctrl_si),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    // Serial modes present 00 on the mode pins
    assign mod0      = mode[0];
    assign mod1      = mode[0] ? mode[1] : 1'b0;
    assign ctrl_load = load_pulse;

    assign sram_addr_rd_readdata = {{(avs_width-mem_addr_width){1'b0}}, rd_addr};
    assign sram_data_rd_readdata = {{(avs_width-mem_data_width){1'b0}}, rd_data};

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the SRAM link testbench with Verilator.
# The run fails when the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module sram_link_tb -Mdir "$OBJ" -f sram_link.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vsram_link_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0

//--- sram_link.f
rtl/sram_link_pkg.sv
rtl/sram_link_regs.sv
rtl/sram_link_sequencer.sv
rtl/sram_link_bit_counter.sv
rtl/sram_link_shifter.sv
rtl/sram_link_top.sv
verification/sram_link_checker.sv
verification/sram_link_tb.sv

//--- verification/sram_link_checker.sv
/*
 * Monitor that checks chip pins, status word, serial output
 * and word readback against the expected values of each entry
 */
`timescale 1ns/100ps

module sram_link_checker (
    input  logic                                csi_clk,
    input  logic                                rsi_reset_n,
    input  logic                                start,
    input  int                                  entry,
    input  logic [7:0]                          exp_ctrl,
    input  logic [3:0]                          exp_status,
    input  logic [sram_link_pkg::word_bits-1:0] exp_tx,
    input  logic [sram_link_pkg::word_bits-1:0] exp_rx,
    input  logic                                reload,
    input  logic [sram_link_pkg::avs_width-1:0] cpustat_readdata,
    input  logic [sram_link_pkg::avs_width-1:0] sram_addr_rd_readdata,
    input  logic [sram_link_pkg::avs_width-1:0] sram_data_rd_readdata,
    input  logic                                cpu_bgn,
    input  logic                                ctrl_load,
    input  logic                                ctrl_bgn,
    input  logic                                mod0,
    input  logic                                mod1,
    input  logic                                rst_n,
    input  logic                                cpu_wait,
    input  logic                                app_done,
    input  logic                                ctrl_si,
    output logic                                done,
    output int                                  checks,
    output int                                  errors
);
    import sram_link_pkg::*;

    int                   cyc;       // Cycles since the accepting edge T
    logic                 running;
    logic                 started;
    logic                 transfer;
    logic [1:0]           mode;
    logic [word_bits-1:0] tx_seen;   // ctrl_si bits, LSB first

    assign mode     = {exp_ctrl[idx_mod1], exp_ctrl[idx_mod0]};
    assign transfer = exp_ctrl[idx_ctrl_load] && (mode == mode_send || mode == mode_receive);

    initial
    begin
        done    = 1'b0;
        running = 1'b0;
        started = 1'b0;
        checks  = 0;
        errors  = 0;
    end

    function automatic string entry_name();
        if (entry < 0)
            return "reset";
        else if (reload)
            return "load_while_busy";
        else if (transfer)
            return (mode == mode_send) ? "send" : "receive";
        else if (exp_ctrl[idx_cpu_bgn])
            return "cpu_bgn_pulse";
        return "control_levels";
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Fail %s (entry %0d) %s: expected %h, actual %h",
                     entry_name(), entry, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // Sampled mid-cycle, away from the DUT clock edge
    // ------------------------------------------------------------
    always @(negedge csi_clk)
    begin
        if (start)
        begin
            cyc     = -1;           // Cycle before T
            running = 1'b1;
            started = 1'b1;
            done    = 1'b0;
            tx_seen = '0;
        end
        else if (running)
        begin
            cyc = cyc + 1;
            // Whole status word apart from busy, unused bits read as zero
            compare_value("status", 32'(exp_status),
                          cpustat_readdata & ~(32'd1 << idx_busy));
            compare_value("levels",
                          32'({exp_ctrl[idx_ctrl_bgn], exp_ctrl[idx_rst_n],
                               exp_ctrl[idx_cpu_wait], exp_ctrl[idx_app_done],
                               exp_ctrl[idx_mod0], exp_ctrl[idx_mod0] & exp_ctrl[idx_mod1]}),
                          32'({ctrl_bgn, rst_n, cpu_wait, app_done, mod0, mod1}));
            if (cyc == 0)
                compare_value("pulses", 32'({exp_ctrl[idx_cpu_bgn], exp_ctrl[idx_ctrl_load]}),
                              32'({cpu_bgn, ctrl_load}));
            else if (cyc <= 2)
                compare_value("pulses", 32'h0, 32'({cpu_bgn, ctrl_load}));  // One shot only
            if (cyc == 2)
                compare_value("busy", 32'(transfer), 32'(cpustat_readdata[idx_busy]));
            if (transfer && cyc >= 2 && cyc < 2 + word_bits)
                tx_seen[cyc-2] = ctrl_si;
            if (transfer && mode == mode_send && cyc == 2 + word_bits)
                compare_value("ctrl_si word", 32'(exp_tx), 32'(tx_seen));

            // Readback valid once busy has dropped
            if (transfer && cyc >= 2 + word_bits && !cpustat_readdata[idx_busy])
            begin
                compare_value("sram_addr_rd", 32'(exp_rx[word_bits-1:mem_data_width]),
                              sram_addr_rd_readdata);
                compare_value("sram_data_rd", 32'(exp_rx[mem_data_width-1:0]),
                              sram_data_rd_readdata);
                running = 1'b0;
                done    = 1'b1;
            end
            else if (!transfer && cyc == 3)
            begin
                running = 1'b0;
                done    = 1'b1;
            end
        end
        else if (rsi_reset_n && !started)
        begin
            compare_value("pins", 32'h0,
                          32'({cpu_bgn, ctrl_load, ctrl_bgn, mod0, mod1, rst_n,
                               cpu_wait, app_done}));
            compare_value("busy", 32'h0, 32'(cpustat_readdata[idx_busy]));
            compare_value("readback", 32'h0, sram_addr_rd_readdata | sram_data_rd_readdata);
        end
    end

endmodule

//--- verification/sram_link_tb.sv
/*
 * Testbench top with clock, reset, stimulus table and LFSR
 * for receive words, driving each entry into the DUT
 */
`timescale 1ns/100ps

module sram_link_tb;
    import sram_link_pkg::*;

    typedef struct packed {
        logic [7:0]                ctrl;
        logic [mem_addr_width-1:0] addr;
        logic [mem_data_width-1:0] data;
        logic [3:0]                status;  // {app_start, nxt_cont, nxt_end, ctrl_rdy}
        logic [1:0]                hold;    // Cycles the control write stays high
        logic                      reload;  // Second load while busy
    } entry_t;

    localparam int n_entries      = 8;
    localparam int timeout_cycles = n_entries * 40 + 100;

    entry_t stim [n_entries];

    logic                 csi_clk;
    logic                 rsi_reset_n;
    logic [avs_width-1:0] cpuctrl_writedata;
    logic [avs_width-1:0] sram_addr_wrt_writedata;
    logic [avs_width-1:0] sram_data_wrt_writedata;
    logic                 cpuctrl_write;
    logic                 sram_addr_wrt_write;
    logic                 sram_data_wrt_write;
    logic [avs_width-1:0] cpustat_readdata;
    logic [avs_width-1:0] sram_addr_rd_readdata;
    logic [avs_width-1:0] sram_data_rd_readdata;
    logic                 cpu_bgn, ctrl_load, ctrl_bgn, mod0, mod1;
    logic                 rst_n, cpu_wait, app_done, ctrl_si;
    logic                 ctrl_so, ctrl_rdy, nxt_end, nxt_cont, app_start;

    // Expected values and status from the checker
    logic                 start;
    int                   entry;
    logic [7:0]           exp_ctrl;
    logic [3:0]           exp_status;
    logic [word_bits-1:0] exp_tx;
    logic [word_bits-1:0] exp_rx;
    logic                 reload;
    logic                 done;
    int                   checks;
    int                   errors;

    sram_link_top sram_link_top_i (.*);          // Port names match one to one
    sram_link_checker sram_link_checker_i (.*);

    initial
    begin
        csi_clk = 1'b0;
        forever #50 csi_clk = ~csi_clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ------------------------------------------------------------
    // One entry: address/data write, control write, serial input
    // ------------------------------------------------------------
    task automatic run_entry(input int n, input logic [word_bits-1:0] rx);
        entry_t e;
        e = stim[n];
        @(posedge csi_clk);
        sram_addr_wrt_writedata <= 32'(e.addr);
        sram_data_wrt_writedata <= 32'(e.data);
        sram_addr_wrt_write     <= 1'b1;
        sram_data_wrt_write     <= 1'b1;
        {app_start, nxt_cont, nxt_end, ctrl_rdy} <= e.status;
        @(posedge csi_clk);                     // Write accepted on the next edge, T
        sram_addr_wrt_write <= 1'b0;
        sram_data_wrt_write <= 1'b0;
        cpuctrl_writedata   <= 32'(e.ctrl);
        cpuctrl_write       <= 1'b1;
        start      <= 1'b1;
        entry      <= n;
        exp_ctrl   <= e.ctrl;
        exp_status <= e.status;
        exp_tx     <= {e.addr, e.data};
        exp_rx     <= rx;
        reload     <= e.reload;
        for (int c = 1; c <= word_bits + 4; c++)
        begin
            @(posedge csi_clk);
            start <= 1'b0;
            if (c == int'(e.hold))
                cpuctrl_write <= 1'b0;
            if (c >= 3 && c < 3 + word_bits)
                ctrl_so <= rx[c-3];             // Sampled at edge T+c
            if (e.reload && c == 8)
            begin
                cpuctrl_write           <= 1'b1;
                sram_addr_wrt_writedata <= 32'(~e.addr);
                sram_addr_wrt_write     <= 1'b1;
            end
            if (e.reload && c == 9)
            begin
                cpuctrl_write       <= 1'b0;
                sram_addr_wrt_write <= 1'b0;
            end
        end
        while (!done)
            @(posedge csi_clk);
    endtask

    initial
    begin
        logic [31:0]          lfsr;
        logic [word_bits-1:0] rx;
        lfsr = 32'hccd74e53;
        rsi_reset_n <= 1'b0;
        cpuctrl_writedata <= '0;
        sram_addr_wrt_writedata <= '0;
        sram_data_wrt_writedata <= '0;
        cpuctrl_write <= 1'b0;
        sram_addr_wrt_write <= 1'b0;
        sram_data_wrt_write <= 1'b0;
        {ctrl_so, ctrl_rdy, nxt_end, nxt_cont, app_start} <= '0;
        {start, exp_ctrl, exp_status, exp_tx, exp_rx, reload} <= '0;
        entry <= -1;
        stim[0] = '{8'hD5, 10'h000, 8'h00, 4'hA, 2'd1, 1'b0};  // Levels, mode 01
        stim[1] = '{8'h0F, 10'h111, 8'h22, 4'h5, 2'd1, 1'b0};  // Mode 11 load, no transfer
        stim[2] = '{8'h60, 10'h000, 8'h00, 4'h3, 2'd3, 1'b0};  // Held cpu_bgn write
        stim[3] = '{8'h42, 10'h2A5, 8'h3C, 4'h9, 2'd1, 1'b0};
        stim[4] = '{8'h4A, 10'h0F0, 8'h0F, 4'h6, 2'd1, 1'b0};
        stim[5] = '{8'hCA, 10'h155, 8'hAA, 4'hF, 2'd1, 1'b1};
        stim[6] = '{8'h43, 10'h15A, 8'hC3, 4'h0, 2'd1, 1'b1};
        stim[7] = '{8'hD2, 10'h3FF, 8'h01, 4'hC, 2'd1, 1'b0};
        repeat (3) @(posedge csi_clk);
        rsi_reset_n <= 1'b1;
        repeat (2) @(posedge csi_clk);
        for (int n = 0; n < n_entries; n++)
        begin
            for (int b = 0; b < word_bits; b++)
            begin
                lfsr  = lfsr_next(lfsr);
                rx[b] = lfsr[0];
            end
            run_entry(n, rx);
        end
        repeat (2) @(posedge csi_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Run limit
    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge csi_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
